// ==== build.f ====
verilog/ram_ports_pkg.sv
verilog/shared_ram.sv
verilog/ram_arbiter.sv
verilog/axi_burst_reader.sv
verilog/axi_burst_writer.sv
verilog/axi_ram_ports.sv
dv/tb_axi_ram_ports.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axi_ram_ports -f build.f

./obj_dir/Vtb_axi_ram_ports | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi

// ==== dv/tb_axi_ram_ports.sv ====
`timescale 1ns/1ps

module tb_axi_ram_ports;
    import ram_ports_pkg::*;

    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   i_reset;

    logic                   ar_valid [N_READERS];
    logic                   ar_ready [N_READERS];
    logic [ADDR_W-1:0]      ar_addr  [N_READERS];
    logic [LEN_W-1:0]       ar_len   [N_READERS];
    logic [ID_W-1:0]        ar_id    [N_READERS];
    logic                   r_valid  [N_READERS];
    logic                   r_ready  [N_READERS];
    logic [DATA_W-1:0]      r_data   [N_READERS];
    logic [ID_W-1:0]        r_id     [N_READERS];
    logic [1:0]             r_resp   [N_READERS];
    logic                   r_last   [N_READERS];

    logic                   aw_valid;
    logic                   aw_ready;
    logic [ADDR_W-1:0]      aw_addr;
    logic [ID_W-1:0]        aw_id;
    logic                   w_valid;
    logic                   w_ready;
    logic [DATA_W-1:0]      w_data;
    logic [STRB_W-1:0]      w_strb;
    logic                   w_last;
    logic                   b_valid;
    logic                   b_ready;
    logic [ID_W-1:0]        b_id;
    logic [1:0]             b_resp;

    // Word model of the RAM contents
    logic [DATA_W-1:0]      model [RAM_DEPTH];
    logic [31:0]            rng_state;
    int                     errors;
    int                     timeouts;

    axi_ram_ports axi_ram_ports_i (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_ar0_valid (ar_valid[0]),
        .o_ar0_ready (ar_ready[0]),
        .i_ar0_addr  (ar_addr[0]),
        .i_ar0_len   (ar_len[0]),
        .i_ar0_id    (ar_id[0]),
        .o_r0_valid  (r_valid[0]),
        .i_r0_ready  (r_ready[0]),
        .o_r0_data   (r_data[0]),
        .o_r0_id     (r_id[0]),
        .o_r0_resp   (r_resp[0]),
        .o_r0_last   (r_last[0]),
        .i_ar1_valid (ar_valid[1]),
        .o_ar1_ready (ar_ready[1]),
        .i_ar1_addr  (ar_addr[1]),
        .i_ar1_len   (ar_len[1]),
        .i_ar1_id    (ar_id[1]),
        .o_r1_valid  (r_valid[1]),
        .i_r1_ready  (r_ready[1]),
        .o_r1_data   (r_data[1]),
        .o_r1_id     (r_id[1]),
        .o_r1_resp   (r_resp[1]),
        .o_r1_last   (r_last[1]),
        .i_ar2_valid (ar_valid[2]),
        .o_ar2_ready (ar_ready[2]),
        .i_ar2_addr  (ar_addr[2]),
        .i_ar2_len   (ar_len[2]),
        .i_ar2_id    (ar_id[2]),
        .o_r2_valid  (r_valid[2]),
        .i_r2_ready  (r_ready[2]),
        .o_r2_data   (r_data[2]),
        .o_r2_id     (r_id[2]),
        .o_r2_resp   (r_resp[2]),
        .o_r2_last   (r_last[2]),
        .i_aw_valid  (aw_valid),
        .o_aw_ready  (aw_ready),
        .i_aw_addr   (aw_addr),
        .i_aw_id     (aw_id),
        .i_w_valid   (w_valid),
        .o_w_ready   (w_ready),
        .i_w_data    (w_data),
        .i_w_strb    (w_strb),
        .i_w_last    (w_last),
        .o_b_valid   (b_valid),
        .i_b_ready   (b_ready),
        .o_b_id      (b_id),
        .o_b_resp    (b_resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Ready low about one cycle in four when stalling
    function automatic logic pick_ready(input bit stall);
        logic [31:0] r;
        r = next_rand();
        return !stall || (r[1:0] != 2'b00);
    endfunction

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out at %0t while waiting for %s", $time, what);
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        #2;
        for (int p = 0; p < N_READERS; p++) begin
            assert (r_valid[p] === 1'b0 && ar_ready[p] === 1'b1) else begin
                errors++;
                $display("** Error at %0t: port %0d rvalid %b arready %b after reset",
                         $time, p, r_valid[p], ar_ready[p]);
            end
        end
        assert (b_valid === 1'b0 && w_ready === 1'b0 && aw_ready === 1'b1) else begin
            errors++;
            $display("** Error at %0t: bvalid %b wready %b awready %b after reset",
                     $time, b_valid, w_ready, aw_ready);
        end
    endtask

    task automatic write_burst(input int addr, input int len, input logic [ID_W-1:0] id,
                               input logic [STRB_W-1:0] strb, input bit stall);
        int          beat;
        int          cycles;
        int          word;
        bit          done;
        bit          seen_b;
        logic [31:0] data;
        @(negedge clk);
        aw_valid = 1'b1;
        aw_addr  = ADDR_W'(addr);
        aw_id    = id;
        cycles   = 0;
        done     = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            #2;
            done = aw_ready;
            @(negedge clk);
            cycles++;
        end
        aw_valid = 1'b0;
        if (!done) begin
            report_timeout("awready on the write port");
            return;
        end
        beat   = 0;
        cycles = 0;
        data   = next_rand();
        while (beat < len && cycles < TIMEOUT) begin
            w_valid = 1'b1;
            w_data  = data;
            w_strb  = strb;
            w_last  = (beat == len - 1);
            #2;
            if (w_ready) begin
                word = (addr / STRB_W + beat) % RAM_DEPTH;
                for (int b = 0; b < STRB_W; b++) begin
                    if (strb[b]) begin
                        model[word][8*b +: 8] = data[8*b +: 8];
                    end
                end
                beat++;
                cycles = 0;
                data   = next_rand();
            end else begin
                cycles++;
            end
            @(negedge clk);
        end
        w_valid = 1'b0;
        w_last  = 1'b0;
        if (beat < len) begin
            report_timeout("wready on the write port");
            return;
        end
        // B response must stay up until taken
        cycles = 0;
        done   = 1'b0;
        seen_b = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            // Under back-pressure the first bvalid cycle is always stalled
            b_ready = seen_b ? pick_ready(stall) : !stall;
            #2;
            if (seen_b) begin
                assert (b_valid === 1'b1) else begin
                    errors++;
                    $display("** Error at %0t: bvalid dropped before bready", $time);
                end
            end
            if (b_valid) begin
                seen_b = 1'b1;
                assert (b_id === id && b_resp === RESP_OKAY) else begin
                    errors++;
                    $display("** Error at %0t: bid %h bresp %b, expected %h and OKAY",
                             $time, b_id, b_resp, id);
                end
                done = b_ready;
            end
            cycles++;
            @(negedge clk);
        end
        b_ready = 1'b0;
        if (!done) begin
            report_timeout("bvalid on the write port");
        end
    endtask

    task automatic read_burst(input int port, input int addr, input int len,
                              input logic [ID_W-1:0] id, input bit stall);
        int                beat;
        int                cycles;
        int                word;
        bit                done;
        bit                stalled;
        logic [DATA_W-1:0] held_data;
        @(negedge clk);
        ar_valid[port] = 1'b1;
        ar_addr[port]  = ADDR_W'(addr);
        ar_len[port]   = LEN_W'(len - 1);
        ar_id[port]    = id;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            #2;
            done = ar_ready[port];
            @(negedge clk);
            cycles++;
        end
        ar_valid[port] = 1'b0;
        if (!done) begin
            report_timeout($sformatf("arready on read port %0d", port));
            return;
        end
        beat      = 0;
        cycles    = 0;
        stalled   = 1'b0;
        held_data = '0;
        while (beat < len && cycles < TIMEOUT) begin
            r_ready[port] = pick_ready(stall);
            #2;
            if (stalled) begin
                assert (r_valid[port] === 1'b1 && r_data[port] === held_data) else begin
                    errors++;
                    $display("** Error at %0t: port %0d stalled beat not held", $time, port);
                end
            end
            stalled   = r_valid[port] && !r_ready[port];
            held_data = r_data[port];
            if (r_valid[port] && r_ready[port]) begin
                word = (addr / STRB_W + beat) % RAM_DEPTH;
                assert (r_data[port] === model[word]) else begin
                    errors++;
                    $display("** Error at %0t: port %0d beat %0d data %h, expected %h",
                             $time, port, beat, r_data[port], model[word]);
                end
                assert (r_last[port] === (beat == len - 1)) else begin
                    errors++;
                    $display("** Error at %0t: port %0d beat %0d of %0d has rlast %b",
                             $time, port, beat + 1, len, r_last[port]);
                end
                assert (r_id[port] === id && r_resp[port] === RESP_OKAY) else begin
                    errors++;
                    $display("** Error at %0t: port %0d rid %h rresp %b, expected %h and OKAY",
                             $time, port, r_id[port], r_resp[port], id);
                end
                beat++;
                cycles = 0;
            end else begin
                cycles++;
            end
            @(negedge clk);
        end
        r_ready[port] = 1'b0;
        if (beat < len) begin
            report_timeout($sformatf("beat %0d on read port %0d", beat + 1, port));
            return;
        end
        // Nothing may follow the last beat
        #2;
        assert (r_valid[port] === 1'b0) else begin
            errors++;
            $display("** Error at %0t: port %0d extra beat after rlast", $time, port);
        end
    endtask

    task automatic test_write_read_all();
        write_burst('h100, 16, 4'h3, 4'hf, 1'b0);
        read_burst(0, 'h100, 16, 4'h5, 1'b0);
        read_burst(1, 'h100, 16, 4'h6, 1'b0);
        read_burst(2, 'h100, 16, 4'h7, 1'b0);
    endtask

    task automatic test_partial_strobes();
        write_burst('h200, 2, 4'h7, 4'hf, 1'b0);
        write_burst('h200, 1, 4'h8, 4'b0101, 1'b0);
        write_burst('h204, 1, 4'h9, 4'b1000, 1'b0);
        read_burst(1, 'h200, 1, 4'h2, 1'b0);
        read_burst(0, 'h204, 1, 4'h4, 1'b0);
    endtask

    task automatic test_concurrent_reads();
        write_burst('h400, 24, 4'h1, 4'hf, 1'b0);
        write_burst('h600, 8, 4'h2, 4'hf, 1'b0);
        write_burst('h800, 13, 4'h3, 4'hf, 1'b0);
        fork
            read_burst(0, 'h400, 24, 4'ha, 1'b0);
            read_burst(1, 'h600, 8, 4'hb, 1'b0);
            read_burst(2, 'h800, 13, 4'hc, 1'b0);
        join
    endtask

    // Random rready and bready while the writer competes for the RAM
    task automatic test_back_pressure();
        write_burst('ha00, 20, 4'hd, 4'hf, 1'b1);
        fork
            write_burst('hc00, 12, 4'he, 4'hf, 1'b1);
            read_burst(0, 'ha00, 20, 4'h1, 1'b1);
            read_burst(1, 'ha10, 11, 4'h2, 1'b1);
            read_burst(2, 'ha20, 7, 4'h3, 1'b1);
        join
        read_burst(1, 'hc00, 12, 4'h4, 1'b1);
    endtask

    task automatic test_single_beat();
        read_burst(2, 'h104, 1, 4'hf, 1'b0);
    endtask

    initial begin
        errors    = 0;
        timeouts  = 0;
        rng_state = 32'd50;
        i_reset   = 1'b1;
        for (int p = 0; p < N_READERS; p++) begin
            ar_valid[p] = 1'b0;
            ar_addr[p]  = '0;
            ar_len[p]   = '0;
            ar_id[p]    = '0;
            r_ready[p]  = 1'b0;
        end
        aw_valid = 1'b0;
        aw_addr  = '0;
        aw_id    = '0;
        w_valid  = 1'b0;
        w_data   = '0;
        w_strb   = '0;
        w_last   = 1'b0;
        b_ready  = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;

        check_reset_state();
        test_write_read_all();
        test_partial_strobes();
        test_concurrent_reads();
        test_back_pressure();
        test_single_beat();

        $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/axi_ram_ports.sv ====
`timescale 1ns/1ps

module axi_ram_ports (
    input  logic                                clk,
    input  logic                                i_reset,

    input  logic                                i_ar0_valid,
    output logic                                o_ar0_ready,
    input  logic [ram_ports_pkg::ADDR_W-1:0]    i_ar0_addr,
    input  logic [ram_ports_pkg::LEN_W-1:0]     i_ar0_len,
    input  logic [ram_ports_pkg::ID_W-1:0]      i_ar0_id,
    output logic                                o_r0_valid,
    input  logic                                i_r0_ready,
    output logic [ram_ports_pkg::DATA_W-1:0]    o_r0_data,
    output logic [ram_ports_pkg::ID_W-1:0]      o_r0_id,
    output logic [1:0]                          o_r0_resp,
    output logic                                o_r0_last,

    input  logic                                i_ar1_valid,
    output logic                                o_ar1_ready,
    input  logic [ram_ports_pkg::ADDR_W-1:0]    i_ar1_addr,
    input  logic [ram_ports_pkg::LEN_W-1:0]     i_ar1_len,
    input  logic [ram_ports_pkg::ID_W-1:0]      i_ar1_id,
    output logic                                o_r1_valid,
    input  logic                                i_r1_ready,
    output logic [ram_ports_pkg::DATA_W-1:0]    o_r1_data,
    output logic [ram_ports_pkg::ID_W-1:0]      o_r1_id,
    output logic [1:0]                          o_r1_resp,
    output logic                                o_r1_last,

    input  logic                                i_ar2_valid,
    output logic                                o_ar2_ready,
    input  logic [ram_ports_pkg::ADDR_W-1:0]    i_ar2_addr,
    input  logic [ram_ports_pkg::LEN_W-1:0]     i_ar2_len,
    input  logic [ram_ports_pkg::ID_W-1:0]      i_ar2_id,
    output logic                                o_r2_valid,
    input  logic                                i_r2_ready,
    output logic [ram_ports_pkg::DATA_W-1:0]    o_r2_data,
    output logic [ram_ports_pkg::ID_W-1:0]      o_r2_id,
    output logic [1:0]                          o_r2_resp,
    output logic                                o_r2_last,

    input  logic                                i_aw_valid,
    output logic                                o_aw_ready,
    input  logic [ram_ports_pkg::ADDR_W-1:0]    i_aw_addr,
    input  logic [ram_ports_pkg::ID_W-1:0]      i_aw_id,
    input  logic                                i_w_valid,
    output logic                                o_w_ready,
    input  logic [ram_ports_pkg::DATA_W-1:0]    i_w_data,
    input  logic [ram_ports_pkg::STRB_W-1:0]    i_w_strb,
    input  logic                                i_w_last,
    output logic                                o_b_valid,
    input  logic                                i_b_ready,
    output logic [ram_ports_pkg::ID_W-1:0]      o_b_id,
    output logic [1:0]                          o_b_resp
);
    import ram_ports_pkg::*;

    logic [N_READERS-1:0]                   ar_valid;
    logic [N_READERS-1:0]                   ar_ready;
    logic [N_READERS-1:0][ADDR_W-1:0]       ar_addr;
    logic [N_READERS-1:0][LEN_W-1:0]        ar_len;
    logic [N_READERS-1:0][ID_W-1:0]         ar_id;
    logic [N_READERS-1:0]                   r_valid;
    logic [N_READERS-1:0]                   r_ready;
    logic [N_READERS-1:0][DATA_W-1:0]       r_data;
    logic [N_READERS-1:0][ID_W-1:0]         r_id;
    logic [N_READERS-1:0][1:0]              r_resp;
    logic [N_READERS-1:0]                   r_last;

    logic [N_REQ-1:0]                       req;
    logic [N_REQ-1:0]                       req_we;
    logic [N_REQ-1:0][WORD_ADDR_W-1:0]      req_addr;
    logic [N_REQ-1:0][DATA_W-1:0]           req_wdata;
    logic [N_REQ-1:0][STRB_W-1:0]           req_wstrb;
    logic [N_REQ-1:0]                       gnt;

    logic                                   ram_en;
    logic                                   ram_we;
    logic [WORD_ADDR_W-1:0]                 ram_addr;
    logic [DATA_W-1:0]                      ram_wdata;
    logic [STRB_W-1:0]                      ram_wstrb;
    logic [DATA_W-1:0]                      ram_rdata;

    // Gather the loose read channels into arrays
    assign ar_valid = {i_ar2_valid, i_ar1_valid, i_ar0_valid};
    assign ar_addr  = {i_ar2_addr, i_ar1_addr, i_ar0_addr};
    assign ar_len   = {i_ar2_len, i_ar1_len, i_ar0_len};
    assign ar_id    = {i_ar2_id, i_ar1_id, i_ar0_id};
    assign r_ready  = {i_r2_ready, i_r1_ready, i_r0_ready};

    assign {o_ar2_ready, o_ar1_ready, o_ar0_ready} = ar_ready;
    assign {o_r2_valid, o_r1_valid, o_r0_valid}    = r_valid;
    assign {o_r2_data, o_r1_data, o_r0_data}       = r_data;
    assign {o_r2_id, o_r1_id, o_r0_id}             = r_id;
    assign {o_r2_resp, o_r1_resp, o_r0_resp}       = r_resp;
    assign {o_r2_last, o_r1_last, o_r0_last}       = r_last;

    for (genvar g = 0; g < N_READERS; g++) begin : gen_reader
        // Readers never write
        assign req_we[g]    = 1'b0;
        assign req_wdata[g] = '0;
        assign req_wstrb[g] = '0;

        axi_burst_reader axi_burst_reader_i (
            .clk        (clk),
            .i_reset    (i_reset),
            .i_ar_valid (ar_valid[g]),
            .o_ar_ready (ar_ready[g]),
            .i_ar_addr  (ar_addr[g]),
            .i_ar_len   (ar_len[g]),
            .i_ar_id    (ar_id[g]),
            .o_r_valid  (r_valid[g]),
            .i_r_ready  (r_ready[g]),
            .o_r_data   (r_data[g]),
            .o_r_id     (r_id[g]),
            .o_r_resp   (r_resp[g]),
            .o_r_last   (r_last[g]),
            .o_req      (req[g]),
            .o_addr     (req_addr[g]),
            .i_gnt      (gnt[g]),
            .i_rdata    (ram_rdata)
        );
    end

    assign req_we[N_READERS] = 1'b1;

    axi_burst_writer axi_burst_writer_i (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_aw_valid (i_aw_valid),
        .o_aw_ready (o_aw_ready),
        .i_aw_addr  (i_aw_addr),
        .i_aw_id    (i_aw_id),
        .i_w_valid  (i_w_valid),
        .o_w_ready  (o_w_ready),
        .i_w_data   (i_w_data),
        .i_w_strb   (i_w_strb),
        .i_w_last   (i_w_last),
        .o_b_valid  (o_b_valid),
        .i_b_ready  (i_b_ready),
        .o_b_id     (o_b_id),
        .o_b_resp   (o_b_resp),
        .o_req      (req[N_READERS]),
        .o_addr     (req_addr[N_READERS]),
        .o_wdata    (req_wdata[N_READERS]),
        .o_wstrb    (req_wstrb[N_READERS]),
        .i_gnt      (gnt[N_READERS])
    );

    ram_arbiter ram_arbiter_i (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_req       (req),
        .i_we        (req_we),
        .i_addr      (req_addr),
        .i_wdata     (req_wdata),
        .i_wstrb     (req_wstrb),
        .o_gnt       (gnt),
        .o_ram_en    (ram_en),
        .o_ram_we    (ram_we),
        .o_ram_addr  (ram_addr),
        .o_ram_wdata (ram_wdata),
        .o_ram_wstrb (ram_wstrb)
    );

    shared_ram shared_ram_i (
        .clk     (clk),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .i_wstrb (ram_wstrb),
        .o_rdata (ram_rdata)
    );

endmodule

// ==== verilog/axi_burst_writer.sv ====
`timescale 1ns/1ps

module axi_burst_writer (
    input  logic                                    clk,
    input  logic                                    i_reset,

    input  logic                                    i_aw_valid,
    output logic                                    o_aw_ready,
    input  logic [ram_ports_pkg::ADDR_W-1:0]        i_aw_addr,
    input  logic [ram_ports_pkg::ID_W-1:0]          i_aw_id,

    input  logic                                    i_w_valid,
    output logic                                    o_w_ready,
    input  logic [ram_ports_pkg::DATA_W-1:0]        i_w_data,
    input  logic [ram_ports_pkg::STRB_W-1:0]        i_w_strb,
    input  logic                                    i_w_last,

    output logic                                    o_b_valid,
    input  logic                                    i_b_ready,
    output logic [ram_ports_pkg::ID_W-1:0]          o_b_id,
    output logic [1:0]                              o_b_resp,

    output logic                                    o_req,
    output logic [ram_ports_pkg::WORD_ADDR_W-1:0]   o_addr,
    output logic [ram_ports_pkg::DATA_W-1:0]        o_wdata,
    output logic [ram_ports_pkg::STRB_W-1:0]        o_wstrb,
    input  logic                                    i_gnt
);
    import ram_ports_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_data,
        s_resp
    } state_t;

    state_t                 state_q;
    logic [WORD_ADDR_W-1:0] addr_q;
    logic [ID_W-1:0]        id_q;

    assign o_aw_ready = (state_q == s_idle);

    // W beat goes straight to the RAM when granted
    assign o_req     = (state_q == s_data) && i_w_valid;
    assign o_w_ready = i_gnt;
    assign o_addr    = addr_q;
    assign o_wdata   = i_w_data;
    assign o_wstrb   = i_w_strb;

    assign o_b_valid = (state_q == s_resp);
    assign o_b_id    = id_q;
    assign o_b_resp  = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q <= s_idle;
        end else begin
            case (state_q)
                s_idle: begin
                    if (i_aw_valid) begin
                        state_q <= s_data;
                    end
                end
                s_data: begin
                    // Burst ends on the written wlast beat
                    if (i_gnt && i_w_last) begin
                        state_q <= s_resp;
                    end
                end
                s_resp: begin
                    if (i_b_ready) begin
                        state_q <= s_idle;
                    end
                end
                default: begin
                    state_q <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_aw_valid && o_aw_ready) begin
            addr_q <= i_aw_addr[ADDR_W-1 -: WORD_ADDR_W];
            id_q   <= i_aw_id;
        end else if (i_gnt) begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

// ==== verilog/axi_burst_reader.sv ====
`timescale 1ns/1ps

module axi_burst_reader (
    input  logic                                    clk,
    input  logic                                    i_reset,

    input  logic                                    i_ar_valid,
    output logic                                    o_ar_ready,
    input  logic [ram_ports_pkg::ADDR_W-1:0]        i_ar_addr,
    input  logic [ram_ports_pkg::LEN_W-1:0]         i_ar_len,
    input  logic [ram_ports_pkg::ID_W-1:0]          i_ar_id,

    output logic                                    o_r_valid,
    input  logic                                    i_r_ready,
    output logic [ram_ports_pkg::DATA_W-1:0]        o_r_data,
    output logic [ram_ports_pkg::ID_W-1:0]          o_r_id,
    output logic [1:0]                              o_r_resp,
    output logic                                    o_r_last,

    output logic                                    o_req,
    output logic [ram_ports_pkg::WORD_ADDR_W-1:0]   o_addr,
    input  logic                                    i_gnt,
    input  logic [ram_ports_pkg::DATA_W-1:0]        i_rdata
);
    import ram_ports_pkg::*;

    logic                   busy_q;
    logic [LEN_W:0]         remaining_q;
    logic [WORD_ADDR_W-1:0] addr_q;
    logic [ID_W-1:0]        id_q;
    logic                   pend_q;
    logic                   pend_last_q;
    logic                   hold_q;
    logic [DATA_W-1:0]      hold_data_q;
    logic                   hold_last_q;

    // Busy until the last beat leaves on R
    assign o_ar_ready = !busy_q;

    // One beat in flight and only when R has room for it
    assign o_req  = busy_q && (remaining_q != '0) && !pend_q && (!hold_q || i_r_ready);
    assign o_addr = addr_q;

    // RAM data passes through in the cycle after the grant
    assign o_r_valid = pend_q || hold_q;
    assign o_r_data  = pend_q ? i_rdata : hold_data_q;
    assign o_r_last  = pend_q ? pend_last_q : hold_last_q;
    assign o_r_id    = id_q;
    assign o_r_resp  = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy_q      <= 1'b0;
            remaining_q <= '0;
            pend_q      <= 1'b0;
            hold_q      <= 1'b0;
        end else begin
            pend_q <= i_gnt;
            if (i_ar_valid && o_ar_ready) begin
                busy_q      <= 1'b1;
                remaining_q <= {1'b0, i_ar_len} + 1'b1;
            end else if (i_gnt) begin
                remaining_q <= remaining_q - 1'b1;
            end
            if (pend_q && !i_r_ready) begin
                hold_q <= 1'b1;
            end else if (hold_q && i_r_ready) begin
                hold_q <= 1'b0;
            end
            if (o_r_valid && i_r_ready && o_r_last) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_ar_valid && o_ar_ready) begin
            addr_q <= i_ar_addr[ADDR_W-1 -: WORD_ADDR_W];
            id_q   <= i_ar_id;
        end else if (i_gnt) begin
            addr_q <= addr_q + 1'b1;
        end
        if (i_gnt) begin
            pend_last_q <= (remaining_q == (LEN_W+1)'(1));
        end
        // Stalled beat parks here
        if (pend_q && !i_r_ready) begin
            hold_data_q <= i_rdata;
            hold_last_q <= pend_last_q;
        end
    end

endmodule

// ==== verilog/ram_arbiter.sv ====
`timescale 1ns/1ps

module ram_arbiter (
    input  logic                                                        clk,
    input  logic                                                        i_reset,

    input  logic [ram_ports_pkg::N_REQ-1:0]                             i_req,
    input  logic [ram_ports_pkg::N_REQ-1:0]                             i_we,
    input  logic [ram_ports_pkg::N_REQ-1:0][ram_ports_pkg::WORD_ADDR_W-1:0] i_addr,
    input  logic [ram_ports_pkg::N_REQ-1:0][ram_ports_pkg::DATA_W-1:0]  i_wdata,
    input  logic [ram_ports_pkg::N_REQ-1:0][ram_ports_pkg::STRB_W-1:0]  i_wstrb,
    output logic [ram_ports_pkg::N_REQ-1:0]                             o_gnt,

    output logic                                                        o_ram_en,
    output logic                                                        o_ram_we,
    output logic [ram_ports_pkg::WORD_ADDR_W-1:0]                       o_ram_addr,
    output logic [ram_ports_pkg::DATA_W-1:0]                            o_ram_wdata,
    output logic [ram_ports_pkg::STRB_W-1:0]                            o_ram_wstrb
);
    import ram_ports_pkg::*;

    typedef logic [$clog2(N_REQ)-1:0] idx_t;

    idx_t last_q;
    idx_t sel;
    idx_t cand;
    logic found;

    // Search starts one past the last winner
    always_comb begin
        sel   = last_q;
        cand  = last_q;
        found = 1'b0;
        for (int k = 1; k <= N_REQ; k++) begin
            cand = idx_t'((int'(last_q) + k) % N_REQ);
            if (!found && i_req[cand]) begin
                found = 1'b1;
                sel   = cand;
            end
        end
    end

    always_comb begin
        o_gnt = '0;
        if (found) begin
            o_gnt[sel] = 1'b1;
        end
    end

    // Winner's request straight onto the RAM port
    assign o_ram_en    = found;
    assign o_ram_we    = i_we[sel];
    assign o_ram_addr  = i_addr[sel];
    assign o_ram_wdata = i_wdata[sel];
    assign o_ram_wstrb = i_wstrb[sel];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            last_q <= idx_t'(N_REQ - 1);
        end else if (found) begin
            last_q <= sel;
        end
    end

endmodule

// ==== verilog/shared_ram.sv ====
`timescale 1ns/1ps

module shared_ram (
    input  logic                                    clk,
    input  logic                                    i_en,
    input  logic                                    i_we,
    input  logic [ram_ports_pkg::WORD_ADDR_W-1:0]   i_addr,
    input  logic [ram_ports_pkg::DATA_W-1:0]        i_wdata,
    input  logic [ram_ports_pkg::STRB_W-1:0]        i_wstrb,
    output logic [ram_ports_pkg::DATA_W-1:0]        o_rdata
);

    logic [ram_ports_pkg::DATA_W-1:0] mem [ram_ports_pkg::RAM_DEPTH];

    // Byte lanes on write, registered read otherwise
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                for (int b = 0; b < ram_ports_pkg::STRB_W; b++) begin
                    if (i_wstrb[b]) begin
                        mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
                    end
                end
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

// ==== verilog/ram_ports_pkg.sv ====
package ram_ports_pkg;

    // Data path
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // AXI side fields
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;
    localparam int ADDR_W = 12;

    // RAM is word addressed
    localparam int WORD_ADDR_W = ADDR_W - $clog2(STRB_W);
    localparam int RAM_DEPTH   = 2 ** WORD_ADDR_W;

    localparam int N_READERS = 3;
    // Writer sits after the readers
    localparam int N_REQ     = N_READERS + 1;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage
